// File: hw/intr_config.svh
// Sizing and register map macros for the interrupt controller, included by RTL and testbench

`ifndef INTR_CONFIG_SVH
`define INTR_CONFIG_SVH

// number of interrupt sources
`define INTR_NUM 16

// width of a source index
`define INTR_ID_W 4

// register port address width
`define REG_ADDR_W 2

// enable mask, read and write
`define REG_ENABLE 2'd0

// pending vector, read only
`define REG_PENDING 2'd1

// acknowledge by id, write only
`define REG_ACK 2'd2

`endif

// File: hw/intr_pkg.sv
// Shared types of the interrupt controller, imported by the RTL modules and the testbench

`default_nettype none

`include "intr_config.svh"

package intr_pkg;

  // one bit per interrupt source
  typedef logic [`INTR_NUM-1:0] intr_vec_t;

  // source index, highest index has highest priority
  typedef logic [`INTR_ID_W-1:0] intr_id_t;

  // register write word
  // enable register uses the mask view, acknowledge uses the id view
  typedef union packed {
    intr_vec_t mask;
    struct packed {
      logic [`INTR_NUM-`INTR_ID_W-1:0] pad;
      intr_id_t                        id;
    } ack;
  } reg_word_u;

  // software register request, one access per cycle
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [`REG_ADDR_W-1:0] addr;
    reg_word_u              wdata;
  } reg_req_t;

  // interrupt output toward the consumer
  typedef struct packed {
    logic     valid;
    intr_id_t id;
  } intr_out_t;

  // acknowledge pulse from register file to pending logic
  typedef struct packed {
    logic     clr;
    intr_id_t id;
  } ack_t;

endpackage

`default_nettype wire

// File: hw/intr_pending.sv
// Rising edge capture of the interrupt sources into the pending register, cleared by acknowledge

`default_nettype none

`include "intr_config.svh"

module intr_pending
  import intr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire intr_vec_t intr_src,
  input  wire ack_t      ack,
  output intr_vec_t      pending
);

  intr_vec_t src_q;
  intr_vec_t rise;
  intr_vec_t clr_mask;

  // previous sample of the sources
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q <= '0;
    end else begin
      src_q <= intr_src;
    end
  end

  // low last edge and high now
  assign rise = intr_src & ~src_q;

  // one-hot clear from the acknowledged id
  always_comb begin
    clr_mask = '0;
    if (ack.clr) begin
      clr_mask[ack.id] = 1'b1;
    end
  end

  // a new edge in the clear cycle wins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | rise;
    end
  end

endmodule

`default_nettype wire

// File: hw/intr_regs.sv
// Register port of the interrupt controller with enable, pending and acknowledge registers

`default_nettype none

`include "intr_config.svh"

module intr_regs
  import intr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire reg_req_t  reg_req,
  input  wire intr_vec_t pending,
  output intr_vec_t      enable,
  output ack_t           ack,
  output intr_vec_t      rdata,
  output logic           rdata_valid
);

  logic      wr_enable;
  logic      wr_ack;
  intr_vec_t rd_mux;

  // address decode
  assign wr_enable = reg_req.wr && (reg_req.addr == `REG_ENABLE);
  assign wr_ack    = reg_req.wr && (reg_req.addr == `REG_ACK);

  // enable mask from the mask view
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable <= '0;
    end else if (wr_enable) begin
      enable <= reg_req.wdata.mask;
    end
  end

  // single cycle strobe, id from the id view
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= '0;
    end else begin
      ack.clr <= wr_ack;
      ack.id  <= reg_req.wdata.ack.id;
    end
  end

  // read select
  // sees register contents before a same-cycle write
  always_comb begin
    case (reg_req.addr)
      `REG_ENABLE: begin
        rd_mux = enable;
      end
      `REG_PENDING: begin
        rd_mux = pending;
      end
      default: begin
        // acknowledge and unmapped addresses
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= reg_req.rd;
    end
  end

  // read data only loads on a read
  always_ff @(posedge clk) begin
    if (reg_req.rd) begin
      rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: hw/intr_prio_pipe.sv
// Masked highest-index priority encoder with a two-stage valid/ready pipeline to the interrupt output

`default_nettype none

`include "intr_config.svh"

module intr_prio_pipe
  import intr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire intr_vec_t pending,
  input  wire intr_vec_t enable,
  input  wire logic      ready,
  output intr_out_t      intr_out
);

  intr_vec_t masked;
  intr_id_t  top_id;
  logic      any_req;
  logic      advance;
  intr_out_t stage_q;

  // gate pending with the software mask
  assign masked  = pending & enable;
  assign any_req = |masked;

  // later hits overwrite so the highest index wins
  always_comb begin
    top_id = '0;
    for (int i = 0; i < `INTR_NUM; i++) begin
      if (masked[i]) begin
        top_id = intr_id_t'(i);
      end
    end
  end

  // output either consumed or empty
  assign advance = ready || !intr_out.valid;

  // stage register, holds under back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
    end else if (advance) begin
      stage_q.valid <= any_req;
      stage_q.id    <= top_id;
    end
  end

  // output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_out <= '0;
    end else if (advance) begin
      intr_out <= stage_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/intr_ctrl_top.sv
// Top level of the interrupt controller joining register file, pending logic and priority pipe

`default_nettype none

module intr_ctrl_top
  import intr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire intr_vec_t intr_src,
  input  wire reg_req_t  reg_req,
  input  wire logic      ready,
  output intr_out_t      intr_out,
  output intr_vec_t      rdata,
  output logic           rdata_valid
);

  intr_vec_t enable;
  intr_vec_t pending;
  ack_t      ack;

  // software register file
  intr_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .reg_req     (reg_req),
    .pending     (pending),
    .enable      (enable),
    .ack         (ack),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  // edge capture and acknowledge clear
  intr_pending u_pending (
    .clk      (clk),
    .rst_n    (rst_n),
    .intr_src (intr_src),
    .ack      (ack),
    .pending  (pending)
  );

  // mask applied inside the pipe
  intr_prio_pipe u_prio_pipe (
    .clk      (clk),
    .rst_n    (rst_n),
    .pending  (pending),
    .enable   (enable),
    .ready    (ready),
    .intr_out (intr_out)
  );

endmodule

`default_nettype wire

// File: bench/intr_ctrl_sva.sv
// Assertions on the interrupt output handshake, reset state and ack strobe, bound into the top

`default_nettype none

module intr_ctrl_sva
  import intr_pkg::*;
(
  input wire logic      clk,
  input wire logic      rst_n,
  input wire logic      ready,
  input wire intr_out_t intr_out,
  input wire ack_t      ack
);

  // failure count, read by the testbench at the end
  int fail_count = 0;

  // output holds while stalled
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    intr_out.valid && !ready |=> $stable(intr_out))
    else begin
      fail_count++;
      $error("intr_out changed while valid and not ready");
    end

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !intr_out.valid)
    else begin
      fail_count++;
      $error("intr_out.valid high right after reset release");
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack.clr |=> !ack.clr)
    else begin
      fail_count++;
      $error("ack strobe high for two cycles");
    end

endmodule

bind intr_ctrl_top intr_ctrl_sva sva0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .ready    (ready),
  .intr_out (intr_out),
  .ack      (ack)
);

`default_nettype wire

// File: bench/intr_ctrl_tb.sv
// Table-driven testbench of the interrupt controller with a reference model and a random phase

`default_nettype none

`include "intr_config.svh"

module intr_ctrl_tb
  import intr_pkg::*;
();

  localparam int N_ROWS = 22;
  localparam int N_RAND = 40;
  localparam int SETTLE = 4;

  typedef enum logic [2:0] {OP_ENABLE, OP_PULSE, OP_HOLD, OP_ACK, OP_READY} op_e;

  // operation and operand, then intr_out and pending once settled
  typedef struct packed {
    op_e       op;
    intr_vec_t arg;
    intr_out_t exp_out;
    intr_vec_t exp_pend;
  } step_t;

  logic      clk;
  logic      rst_n;
  intr_vec_t intr_src;
  reg_req_t  reg_req;
  logic      ready;
  intr_out_t intr_out;
  intr_vec_t rdata;
  logic      rdata_valid;

  step_t     steps [N_ROWS];
  int        n_steps;
  integer    seed;
  // reference model
  intr_vec_t model_en;
  intr_vec_t model_pend;
  intr_vec_t src_hold;

  intr_ctrl_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .intr_src    (intr_src),
    .reg_req     (reg_req),
    .ready       (ready),
    .intr_out    (intr_out),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 20 cycles per step is far more than any step takes
  initial begin
    #((N_ROWS + N_RAND) * 20 * 4);
    fail_run("watchdog expired, the test did not finish in time");
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_out(input string name, input intr_out_t got, input intr_out_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_vec(input string name, input intr_vec_t got, input intr_vec_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // highest enabled pending source, scanned from the top
  function automatic intr_out_t expected_out();
    intr_out_t res;
    res = '0;
    for (int i = `INTR_NUM - 1; i >= 0; i--) begin
      if (!res.valid && model_pend[i] && model_en[i]) begin
        res = '{valid: 1'b1, id: intr_id_t'(i)};
      end
    end
    return res;
  endfunction

  task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr, input reg_word_u w);
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = w;
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  // read data valid for exactly one cycle after the strobe edge
  task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr, output intr_vec_t val);
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    @(posedge clk);
    #1;
    reg_req = '0;
    check_bit("rdata_valid", rdata_valid, 1'b1);
    val = rdata;
    @(posedge clk);
    #1;
    check_bit("rdata_valid", rdata_valid, 1'b0);
  endtask

  task automatic apply_op(input op_e op, input intr_vec_t arg);
    reg_word_u w;
    w = '0;
    case (op)
      OP_ENABLE: begin
        model_en = arg;
        w.mask   = arg;
        write_reg(`REG_ENABLE, w);
      end
      OP_ACK: begin
        model_pend[arg[`INTR_ID_W-1:0]] = 1'b0;
        w.ack.id = intr_id_t'(arg);
        write_reg(`REG_ACK, w);
      end
      OP_PULSE, OP_HOLD: begin
        // only low to high transitions set pending
        model_pend |= arg & ~src_hold;
        intr_src = (op == OP_HOLD) ? arg : (src_hold | arg);
        @(posedge clk);
        #1;
        if (op == OP_HOLD) begin
          src_hold = arg;
        end
        intr_src = src_hold;
      end
      default: ready = arg[0];
    endcase
  endtask

  task automatic settle_check(input intr_out_t exp_out, input intr_vec_t exp_pend);
    intr_vec_t rd_val;
    repeat (SETTLE) @(posedge clk);
    #1;
    check_out("intr_out", intr_out, exp_out);
    read_reg(`REG_PENDING, rd_val);
    check_vec("rdata(pending)", rd_val, exp_pend);
    read_reg(`REG_ENABLE, rd_val);
    check_vec("rdata(enable)", rd_val, model_en);
  endtask

  task automatic random_step();
    integer    r;
    intr_out_t top;
    r   = $random(seed);
    top = expected_out();
    case (r[1:0])
      2'd0: apply_op(OP_PULSE, intr_vec_t'(1) << r[7:4]);
      2'd1: apply_op(OP_ENABLE, r[31:16]);
      default: apply_op(OP_ACK, intr_vec_t'(top.valid ? top.id : r[11:8]));
    endcase
    settle_check(expected_out(), model_pend);
  endtask

  task automatic add_step(input op_e op, input intr_vec_t arg, input intr_out_t out,
                          input intr_vec_t pend);
    steps[n_steps] = '{op, arg, out, pend};
    n_steps++;
  endtask

  initial begin
    rst_n      = 1'b0;
    intr_src   = '0;
    reg_req    = '0;
    ready      = 1'b1;
    model_en   = '0;
    model_pend = '0;
    src_hold   = '0;
    seed       = 32'h2670_2a44;
    n_steps    = 0;
    // reset state
    add_step(OP_READY, 16'h0001, 5'h00, 16'h0000);
    // priority order 12, 9, 3
    add_step(OP_ENABLE, 16'hffff, 5'h00, 16'h0000);
    add_step(OP_PULSE, 16'h1208, 5'h1c, 16'h1208);
    add_step(OP_ACK, 16'd12, 5'h19, 16'h0208);
    add_step(OP_ACK, 16'd9, 5'h13, 16'h0008);
    add_step(OP_ACK, 16'd3, 5'h00, 16'h0000);
    // masked source 10
    add_step(OP_ENABLE, 16'h00ff, 5'h00, 16'h0000);
    add_step(OP_PULSE, 16'h0400, 5'h00, 16'h0400);
    add_step(OP_ENABLE, 16'h04ff, 5'h1a, 16'h0400);
    add_step(OP_ACK, 16'd10, 5'h00, 16'h0000);
    // source 5 held high, needs a new edge
    add_step(OP_ENABLE, 16'hffff, 5'h00, 16'h0000);
    add_step(OP_HOLD, 16'h0020, 5'h15, 16'h0020);
    add_step(OP_ACK, 16'd5, 5'h00, 16'h0000);
    add_step(OP_HOLD, 16'h0000, 5'h00, 16'h0000);
    add_step(OP_HOLD, 16'h0020, 5'h15, 16'h0020);
    add_step(OP_ACK, 16'd5, 5'h00, 16'h0000);
    // stalled output keeps id 1 until ready
    add_step(OP_READY, 16'h0000, 5'h00, 16'h0000);
    add_step(OP_PULSE, 16'h0002, 5'h11, 16'h0002);
    add_step(OP_PULSE, 16'h0100, 5'h11, 16'h0102);
    add_step(OP_READY, 16'h0001, 5'h18, 16'h0102);
    add_step(OP_ACK, 16'd8, 5'h11, 16'h0002);
    add_step(OP_ACK, 16'd1, 5'h00, 16'h0000);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_steps; i++) begin
      apply_op(steps[i].op, steps[i].arg);
      settle_check(steps[i].exp_out, steps[i].exp_pend);
    end
    for (int i = 0; i < N_RAND; i++) begin
      random_step();
    end
    if (dut0.sva0.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("bound assertions reported failures during the run");
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/intr_pkg.sv
hw/intr_pending.sv
hw/intr_regs.sv
hw/intr_prio_pipe.sv
hw/intr_ctrl_top.sv
bench/intr_ctrl_sva.sv
bench/intr_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the interrupt controller testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module intr_ctrl_tb \
  -Mdir obj_dir -o intr_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/intr_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
